// ==== exec_stage.f ====
+incdir+include
verilog/exec_pkg.sv
verilog/exec_decode.sv
verilog/exec_alu.sv
verilog/exec_mem_req.sv
verilog/exec_stage_reg.sv
verilog/exec_top.sv
tests/tb_exec_top.sv

// ==== run.sh ====
#!/bin/sh
# build and run the execute stage testbench, then scan the log
verilator --binary --assert -f exec_stage.f --top-module tb_exec_top -o sim_exec \
    && ./obj_dir/sim_exec > sim.log 2>&1 \
    || { cat sim.log 2>/dev/null; echo "build or simulation error"; exit 1; }
cat sim.log
grep -q "=== FAIL ===" sim.log && exit 1 || exit 0

// ==== include/exec_tb_model.svh ====
`ifndef EXEC_TB_MODEL_SVH
`define EXEC_TB_MODEL_SVH

function automatic logic known_op(logic [5:0] op);
    return op inside {op_special, [6'h08:6'h0f], op_lb, op_lh, op_lw, op_lbu, op_lhu,
                      op_sb, op_sh, op_sw};
endfunction

function automatic logic known_fn(logic [5:0] fn);
    return fn inside {fn_sll, fn_srl, fn_sra, fn_sllv, fn_srlv, fn_srav, fn_add, fn_addu,
                      fn_sub, fn_subu, fn_and, fn_or, fn_xor, fn_nor, fn_slt, fn_sltu};
endfunction

function automatic logic bad_encoding(logic [31:0] w);
    return !known_op(w[31:26]) || (w[31:26] == op_special && !known_fn(w[5:0]));
endfunction

function automatic logic is_mem(logic [5:0] op);
    return known_op(op) && op[5];
endfunction

function automatic logic is_store(logic [5:0] op);
    return op inside {op_sb, op_sh, op_sw};
endfunction

// low address bits that must be zero
function automatic logic [1:0] access_mask(logic [5:0] op);
    if (op inside {op_lw, op_sw}) return 2'b11;
    if (op inside {op_lh, op_lhu, op_sh}) return 2'b01;
    return 2'b00;
endfunction

// logical immediates are zero extended
function automatic logic [31:0] ext_imm(logic [31:0] w);
    if (w[31:26] inside {op_andi, op_ori, op_xori}) return {16'h0000, w[15:0]};
    return {{16{w[15]}}, w[15:0]};
endfunction

function automatic logic [31:0] exp_result(logic [31:0] w, logic [31:0] rs, logic [31:0] rt);
    logic [31:0] b;
    logic [4:0]  sh;
    b  = ext_imm(w);
    sh = w[10:6];
    if (w[31:26] != op_special) begin
        case (w[31:26])
            op_slti:  return {31'b0, $signed(rs) < $signed(b)};
            op_sltiu: return {31'b0, rs < b};
            op_andi:  return rs & b;
            op_ori:   return rs | b;
            op_xori:  return rs ^ b;
            op_lui:   return {w[15:0], 16'h0000};
            default:  return rs + b;
        endcase
    end
    case (w[5:0])
        fn_sll:           return rt << sh;
        fn_srl:           return rt >> sh;
        fn_sra:           return $signed(rt) >>> sh;
        fn_sllv:          return rt << rs[4:0];
        fn_srlv:          return rt >> rs[4:0];
        fn_srav:          return $signed(rt) >>> rs[4:0];
        fn_sub, fn_subu:  return rs - rt;
        fn_and:           return rs & rt;
        fn_or:            return rs | rt;
        fn_xor:           return rs ^ rt;
        fn_nor:           return ~(rs | rt);
        fn_slt:           return {31'b0, $signed(rs) < $signed(rt)};
        fn_sltu:          return {31'b0, rs < rt};
        default:          return rs + rt;
    endcase
endfunction

// priority ri, ov, adel, ades
function automatic logic [4:0] exp_code(logic [31:0] w, logic [31:0] rs, logic [31:0] rt);
    logic [32:0] s;
    logic [31:0] b;
    logic [31:0] ea;
    b  = ext_imm(w);
    ea = rs + b;
    s  = '0;
    if (bad_encoding(w)) return exc_ri;
    if (w[31:26] == op_special && w[5:0] == fn_add) s = {rs[31], rs} + {rt[31], rt};
    if (w[31:26] == op_special && w[5:0] == fn_sub) s = {rs[31], rs} - {rt[31], rt};
    if (w[31:26] == op_addi) s = {rs[31], rs} + {b[31], b};
    if (s[32] != s[31]) return exc_ov;
    if (is_mem(w[31:26]) && (ea[1:0] & access_mask(w[31:26])) != 2'b00) begin
        return is_store(w[31:26]) ? exc_ades : exc_adel;
    end
    return 5'h00;
endfunction

function automatic logic [4:0] exp_waddr(logic [31:0] w);
    if (bad_encoding(w) || is_store(w[31:26])) return 5'd0;
    return (w[31:26] == op_special) ? w[15:11] : w[20:16];
endfunction

function automatic mem_op_e exp_memop(logic [5:0] op);
    case (op)
        op_lb:   return mem_lb;
        op_lbu:  return mem_lbu;
        op_lh:   return mem_lh;
        op_lhu:  return mem_lhu;
        op_lw:   return mem_lw;
        op_sb:   return mem_sb;
        op_sh:   return mem_sh;
        op_sw:   return mem_sw;
        default: return mem_none;
    endcase
endfunction

function automatic logic [3:0] exp_strobe(logic [5:0] op, logic [31:0] ea);
    if (op == op_sw) return 4'hf;
    if (op == op_sh) return 4'h3 << ea[1:0];
    if (op == op_sb) return 4'h1 << ea[1:0];
    return 4'h0;
endfunction

function automatic logic [31:0] exp_wdata(logic [5:0] op, logic [31:0] rt);
    if (access_mask(op) == 2'b11) return rt;
    if (access_mask(op) == 2'b01) return {2{rt[15:0]}};
    return {4{rt[7:0]}};
endfunction

function automatic logic [1:0] exp_size(logic [5:0] op);
    if (access_mask(op) == 2'b11) return 2'd2;
    if (access_mask(op) == 2'b01) return 2'd1;
    return 2'd0;
endfunction

`endif

// ==== tests/tb_exec_top.sv ====
module tb_exec_top;
    import exec_pkg::*;
    `include "exec_tb_model.svh"

    localparam int n_total = 820;
    localparam logic [5:0] alu_functs [16] = '{fn_sll, fn_srl, fn_sra, fn_sllv, fn_srlv,
        fn_srav, fn_add, fn_addu, fn_sub, fn_subu, fn_and, fn_or, fn_xor, fn_nor, fn_slt,
        fn_sltu};
    localparam logic [5:0] mem_ops [8] = '{op_lb, op_lbu, op_lh, op_lhu, op_lw, op_sb,
        op_sh, op_sw};
    localparam logic [5:0] wide_ops [5] = '{op_lh, op_lhu, op_lw, op_sh, op_sw};

    logic        clk;
    logic        resetn;
    logic        valid_i;
    logic [31:0] pc_i;
    inst_u       inst_i;
    logic [31:0] rs_data_i;
    logic [31:0] rt_data_i;
    logic        done_o;
    logic        ready_i;
    logic        valid_o;
    exec_out_t   out_o;
    logic        data_req_o;
    logic        data_wr_o;
    logic [3:0]  data_wstrb_o;
    logic [1:0]  data_size_o;
    logic [31:0] data_addr_o;
    logic [31:0] data_wdata_o;
    logic        data_addr_ok_i;
    logic        commit_o;
    logic [4:0]  commit_code_o;

    int seed = 16;
    int errors = 0;
    int issued = 0;
    int pushed = 0;
    int delivered = 0;
    int wait_cnt = 0;
    logic accepted = 1'b0;
    logic req_seen = 1'b0;
    logic load_prev = 1'b1;
    logic expect_valid_prev = 1'b0;
    logic valid_prev = 1'b0;
    exec_out_t out_prev;
    exec_out_t exp_q[$];

    exec_top dut0 (.*);

    initial clk = 1'b0;
    always #5 clk = ~clk;

    task automatic compare_value(input string name, input logic [31:0] got,
                                 input logic [31:0] exp);
        assert (got === exp) else begin
            $display("error %s: got %h expected %h", name, got, exp);
            errors++;
        end
    endtask

    task automatic require(input logic cond, input string what);
        assert (cond) else begin
            $display("%s", what);
            errors++;
        end
    endtask

    always @(posedge clk) begin
        logic [4:0]  code;
        logic [31:0] ea;
        logic [5:0]  op;
        exec_out_t   e;
        if (resetn) begin
            code = exp_code(inst_i, rs_data_i, rt_data_i);
            ea   = rs_data_i + ext_imm(inst_i);
            op   = inst_i[31:26];
            // output register loads only when ready_i was high
            if (load_prev) begin
                compare_value("valid_o", 32'(valid_o), 32'(expect_valid_prev));
                if (valid_o && exp_q.size() > 0) begin
                    e = exp_q.pop_front();
                    delivered++;
                    compare_value("out_o.pc", out_o.pc, e.pc);
                    compare_value("out_o.result", out_o.result, e.result);
                    compare_value("out_o.mem_op", 32'(out_o.mem_op), 32'(e.mem_op));
                    compare_value("out_o.eaddr", out_o.eaddr, e.eaddr);
                    compare_value("out_o.waddr", 32'(out_o.waddr), 32'(e.waddr));
                    compare_value("out_o.rt_data", out_o.rt_data, e.rt_data);
                end
            end else begin
                require(valid_o === valid_prev && out_o === out_prev,
                        "output register changed while the next stage stalled");
            end
            valid_prev = valid_o;
            out_prev = out_o;
            load_prev = ready_i;
            expect_valid_prev = 1'b0;
            if (valid_i) begin
                compare_value("done_o", 32'(done_o),
                              32'(code != 5'h00 || !is_mem(op) || req_seen || data_addr_ok_i));
                compare_value("data_req_o", 32'(data_req_o),
                              32'(code == 5'h00 && is_mem(op) && !req_seen));
                compare_value("commit_o", 32'(commit_o), 32'(code != 5'h00));
                if (commit_o) compare_value("commit_code_o", 32'(commit_code_o), 32'(code));
                if (data_req_o && data_addr_ok_i) begin
                    require(!req_seen, "memory request repeated for one instruction");
                    compare_value("data_addr_o", data_addr_o, {3'b000, ea[28:2], 2'b00});
                    compare_value("data_wstrb_o", 32'(data_wstrb_o), 32'(exp_strobe(op, ea)));
                    compare_value("data_size_o", 32'(data_size_o), 32'(exp_size(op)));
                    compare_value("data_wr_o", 32'(data_wr_o), 32'(is_store(op)));
                    if (is_store(op)) begin
                        compare_value("data_wdata_o", data_wdata_o, exp_wdata(op, rt_data_i));
                    end
                    req_seen = 1'b1;
                end
                if (done_o && ready_i) begin
                    if (code == 5'h00 && is_mem(op)) begin
                        require(req_seen, "memory instruction finished without a request");
                    end
                    accepted = 1'b1;
                    if (code == 5'h00) begin
                        e.pc      = pc_i;
                        e.result  = exp_result(inst_i, rs_data_i, rt_data_i);
                        e.mem_op  = exp_memop(op);
                        e.eaddr   = ea;
                        e.waddr   = exp_waddr(inst_i);
                        e.rt_data = rt_data_i;
                        exp_q.push_back(e);
                        pushed++;
                        expect_valid_prev = 1'b1;
                    end
                end
            end
        end
    end

    // kinds 1 alu, 2 immediate, 3 traps, 4 aligned memory, 5 misaligned, 6 mixed
    task automatic make_instr(input int kind, output logic [31:0] w, output logic [31:0] rs,
                              output logic [31:0] rt);
        logic [31:0] r;
        logic [31:0] ea;
        logic [1:0]  off;
        int sel;
        w = $random(seed);
        rs = $random(seed);
        rt = $random(seed);
        r = $random(seed);
        sel = (kind == 6) ? 1 + int'(r[7:0]) % 5 : kind;
        case (sel)
            1: begin
                w[31:26] = op_special;
                w[5:0] = alu_functs[r[11:8]];
            end
            2: w[31:26] = 6'h08 + {3'b000, r[10:8]};
            3: begin
                w[31:26] = op_special;
                case (int'(r[10:8]) % 5)
                    0, 3: begin
                        w[5:0] = (r[10:8] == 3'd0) ? fn_add : fn_addu;
                        rs = 32'h7000_0000 | {4'h0, rs[27:0]};
                        rt = 32'h1000_0000 | {4'h0, rt[27:0]};
                    end
                    1: begin
                        w[5:0] = fn_sub;
                        rs = 32'h8000_0000 | {4'h0, rs[27:0]};
                        rt = 32'h1000_0000 | {4'h0, rt[27:0]};
                    end
                    2: begin
                        w[31:26] = op_addi;
                        w[15:0] = {2'b01, r[25:12]};
                        rs = 32'h7fff_c000 | {18'h0, rs[13:0]};
                    end
                    default: begin
                        w[31:26] = r[31:26];
                        while (known_op(w[31:26])) w[31:26] = w[31:26] + 6'd1;
                    end
                endcase
            end
            default: begin
                w[31:26] = (sel == 4) ? mem_ops[r[10:8]] : wide_ops[int'(r[10:8]) % 5];
                ea = rs + ext_imm(w);
                off = 2'b00;
                if (sel == 5) begin
                    off = (access_mask(w[31:26]) == 2'b01) ? {r[12], 1'b1} :
                          (r[13:12] == 2'b00) ? 2'b01 : r[13:12];
                end
                rs = rs - 32'(ea[1:0] & access_mask(w[31:26])) + 32'(off);
            end
        endcase
    endtask

    task automatic run_test(input int kind, input int n, input string name);
        logic [31:0] w;
        logic [31:0] rs;
        logic [31:0] rt;
        logic [31:0] r;
        int start_err;
        start_err = errors;
        for (int k = 0; k < n; k++) begin
            make_instr(kind, w, rs, rt);
            r = $random(seed);
            inst_i = w;
            rs_data_i = rs;
            rt_data_i = rt;
            pc_i = 32'h0040_0000 + issued * 4;
            valid_i = 1'b1;
            req_seen = 1'b0;
            accepted = 1'b0;
            ready_i = (r[1:0] != 2'b00);
            wait_cnt = int'(r[3:2]);
            data_addr_ok_i = (wait_cnt == 0);
            while (!accepted) begin
                @(posedge clk);
                #1;
                if (!accepted) begin
                    r = $random(seed);
                    ready_i = (r[1:0] != 2'b00);
                    if (wait_cnt > 0) wait_cnt--;
                    data_addr_ok_i = (wait_cnt == 0);
                end
            end
            issued++;
        end
        valid_i = 1'b0;
        ready_i = 1'b1;
        data_addr_ok_i = 1'b0;
        repeat (2) @(posedge clk);
        #1;
        $display("test %0d %s: %0d instructions, %0d errors", kind, name, n,
                 errors - start_err);
    endtask

    initial begin
        #(n_total * 20 * 10);
        $display("watchdog expired before all instructions were accepted");
        $display("=== FAIL ===");
        $finish;
    end

    initial begin
        resetn = 1'b0;
        valid_i = 1'b0;
        ready_i = 1'b1;
        pc_i = '0;
        inst_i = '0;
        rs_data_i = '0;
        rt_data_i = '0;
        data_addr_ok_i = 1'b0;
        repeat (2) @(posedge clk);
        #1;
        resetn = 1'b1;
        run_test(1, 80, "register alu");
        run_test(2, 80, "immediate alu");
        run_test(3, 40, "overflow and reserved");
        run_test(4, 80, "aligned loads and stores");
        run_test(5, 40, "misaligned accesses");
        run_test(6, 500, "mixed under back-pressure");
        require(exp_q.size() == 0 && delivered == pushed,
                "instructions lost or duplicated at the output");
        $display("instructions %0d, delivered %0d of %0d, errors %0d", issued, delivered,
                 pushed, errors);
        if (errors == 0) begin
            $display("=== PASS ===");
        end else begin
            $display("=== FAIL ===");
        end
        $finish;
    end

endmodule

// ==== verilog/exec_alu.sv ====
module exec_alu (
    input  exec_pkg::exec_ctrl_t        ctrl_i,
    input  exec_pkg::inst_u             inst_i,
    input  logic [exec_pkg::data_w-1:0] rs_data_i,
    input  logic [exec_pkg::data_w-1:0] rt_data_i,
    input  logic [exec_pkg::data_w-1:0] imm_i,
    output logic [exec_pkg::data_w-1:0] result_o,
    output logic                        ovf_o
);
    import exec_pkg::*;

    logic [data_w-1:0] a;
    logic [data_w-1:0] b;
    logic [data_w-1:0] sum;
    logic [data_w-1:0] diff;
    logic [data_w-1:0] alu_res;
    logic              add_ovf;
    logic              sub_ovf;

    assign a    = ctrl_i.a_is_shamt ? {{(data_w-reg_w){1'b0}}, inst_i.r.shamt} : rs_data_i;
    assign b    = ctrl_i.b_is_imm ? imm_i : rt_data_i;
    assign sum  = a + b;
    assign diff = a - b;

    // sign of the result disagrees with what the operand signs allow
    assign add_ovf = (a[data_w-1] == b[data_w-1]) && (sum[data_w-1] != a[data_w-1]);
    assign sub_ovf = (a[data_w-1] != b[data_w-1]) && (diff[data_w-1] != a[data_w-1]);

    always_comb begin
        case (ctrl_i.alu_op)
            alu_add:  alu_res = sum;
            alu_sub:  alu_res = diff;
            alu_and:  alu_res = a & b;
            alu_or:   alu_res = a | b;
            alu_xor:  alu_res = a ^ b;
            alu_nor:  alu_res = ~(a | b);
            alu_slt:  alu_res = {{(data_w-1){1'b0}}, $signed(a) < $signed(b)};
            alu_sltu: alu_res = {{(data_w-1){1'b0}}, a < b};
            alu_sll:  alu_res = b << a[reg_w-1:0];
            alu_srl:  alu_res = b >> a[reg_w-1:0];
            alu_sra:  alu_res = $signed(b) >>> a[reg_w-1:0];
            default:  alu_res = '0;
        endcase
    end

    assign result_o = ctrl_i.is_lui ? {inst_i.i.imm, 16'h0000} : alu_res;
    assign ovf_o    = ctrl_i.trap_on_ovf && ((ctrl_i.alu_op == alu_sub) ? sub_ovf : add_ovf);

    // operands come from the register read upstream
    always_comb begin
        if (!$isunknown(ctrl_i)) begin
            assert (!$isunknown(result_o)) else $error("alu result unknown for known control");
        end
    end

endmodule

// ==== verilog/exec_decode.sv ====
module exec_decode (
    input  exec_pkg::inst_u             inst_i,
    output exec_pkg::exec_ctrl_t        ctrl_o,
    output logic [exec_pkg::reg_w-1:0]  waddr_o,
    output logic [exec_pkg::data_w-1:0] imm_o
);
    import exec_pkg::*;

    logic rd_dest;
    logic zero_ext;

    assign rd_dest  = (inst_i.r.opcode == op_special);
    assign zero_ext = inst_i.i.opcode inside {op_andi, op_ori, op_xori};

    always_comb begin
        ctrl_o             = '0;
        ctrl_o.alu_op      = alu_add;
        ctrl_o.mem_op      = mem_none;
        ctrl_o.writes_reg  = 1'b1;
        ctrl_o.b_is_imm    = !rd_dest;
        // constant shifts take the amount from the shamt field
        ctrl_o.a_is_shamt  = rd_dest && (inst_i.r.funct inside {fn_sll, fn_srl, fn_sra});
        case (inst_i.r.opcode)
            op_special: begin
                ctrl_o.trap_on_ovf = inst_i.r.funct inside {fn_add, fn_sub};
                case (inst_i.r.funct)
                    fn_add, fn_addu:  ctrl_o.alu_op = alu_add;
                    fn_sub, fn_subu:  ctrl_o.alu_op = alu_sub;
                    fn_and:           ctrl_o.alu_op = alu_and;
                    fn_or:            ctrl_o.alu_op = alu_or;
                    fn_xor:           ctrl_o.alu_op = alu_xor;
                    fn_nor:           ctrl_o.alu_op = alu_nor;
                    fn_slt:           ctrl_o.alu_op = alu_slt;
                    fn_sltu:          ctrl_o.alu_op = alu_sltu;
                    fn_sll, fn_sllv:  ctrl_o.alu_op = alu_sll;
                    fn_srl, fn_srlv:  ctrl_o.alu_op = alu_srl;
                    fn_sra, fn_srav:  ctrl_o.alu_op = alu_sra;
                    default:          ctrl_o.reserved = 1'b1;
                endcase
            end
            op_addi:   ctrl_o.trap_on_ovf = 1'b1;
            op_addiu:  ctrl_o.alu_op = alu_add;
            op_slti:   ctrl_o.alu_op = alu_slt;
            op_sltiu:  ctrl_o.alu_op = alu_sltu;
            op_andi:   ctrl_o.alu_op = alu_and;
            op_ori:    ctrl_o.alu_op = alu_or;
            op_xori:   ctrl_o.alu_op = alu_xor;
            op_lui:    ctrl_o.is_lui = 1'b1;
            op_lb:     ctrl_o.mem_op = mem_lb;
            op_lbu:    ctrl_o.mem_op = mem_lbu;
            op_lh:     ctrl_o.mem_op = mem_lh;
            op_lhu:    ctrl_o.mem_op = mem_lhu;
            op_lw:     ctrl_o.mem_op = mem_lw;
            op_sb:     ctrl_o.mem_op = mem_sb;
            op_sh:     ctrl_o.mem_op = mem_sh;
            op_sw:     ctrl_o.mem_op = mem_sw;
            default:   ctrl_o.reserved = 1'b1;
        endcase
        // stores and bad encodings leave the register file alone
        if (ctrl_o.reserved || (ctrl_o.mem_op inside {mem_sb, mem_sh, mem_sw})) begin
            ctrl_o.writes_reg = 1'b0;
        end
    end

    assign waddr_o = !ctrl_o.writes_reg ? '0 :
                     rd_dest            ? inst_i.r.rd : inst_i.i.rt;

    assign imm_o = zero_ext ? {16'h0000, inst_i.i.imm} : {{16{inst_i.i.imm[15]}}, inst_i.i.imm};

endmodule

// ==== verilog/exec_mem_req.sv ====
module exec_mem_req (
    input  logic                        valid_i,
    input  exec_pkg::exec_ctrl_t        ctrl_i,
    input  logic [exec_pkg::data_w-1:0] rs_data_i,
    input  logic [exec_pkg::data_w-1:0] rt_data_i,
    input  logic [exec_pkg::data_w-1:0] imm_i,
    input  logic                        block_i,
    output logic [exec_pkg::data_w-1:0] eaddr_o,
    output logic                        adel_o,
    output logic                        ades_o,
    output logic                        data_req_o,
    output logic                        data_wr_o,
    output logic [3:0]                  data_wstrb_o,
    output logic [1:0]                  data_size_o,
    output logic [exec_pkg::data_w-1:0] data_addr_o,
    output logic [exec_pkg::data_w-1:0] data_wdata_o
);
    import exec_pkg::*;

    logic is_half;
    logic is_word;
    logic is_store;
    logic [1:0] ofs;

    // imm is already sign extended for every load and store
    assign eaddr_o = rs_data_i + imm_i;
    assign ofs     = eaddr_o[1:0];

    assign is_half  = ctrl_i.mem_op inside {mem_lh, mem_lhu, mem_sh};
    assign is_word  = ctrl_i.mem_op inside {mem_lw, mem_sw};
    assign is_store = ctrl_i.mem_op inside {mem_sb, mem_sh, mem_sw};

    assign adel_o = !is_store && (is_half && ofs[0] || is_word && ofs != 2'b00);
    assign ades_o = is_store && (is_half && ofs[0] || is_word && ofs != 2'b00);

    // block_i covers every exception, so a misaligned access never goes out
    assign data_req_o = valid_i && (ctrl_i.mem_op != mem_none) && !block_i;
    assign data_wr_o  = is_store;
    assign data_size_o = is_word ? 2'd2 : is_half ? 2'd1 : 2'd0;

    always_comb begin
        data_wstrb_o = 4'b0000;
        if (is_store) begin
            if (is_word) begin
                data_wstrb_o = 4'b1111;
            end else if (is_half) begin
                data_wstrb_o = 4'b0011 << ofs;
            end else begin
                data_wstrb_o = 4'b0001 << ofs;
            end
        end
    end

    assign data_wdata_o = is_word ? rt_data_i :
                          is_half ? {2{rt_data_i[15:0]}} : {4{rt_data_i[7:0]}};

    // unmapped segment clears the top three bits
    assign data_addr_o = {3'b000, eaddr_o[data_w-4:2], 2'b00};

    always_comb begin
        if (data_req_o) begin
            assert (!(adel_o || ades_o)) else $error("memory request with address error");
        end
    end

endmodule

// ==== verilog/exec_pkg.sv ====
package exec_pkg;

    localparam int data_w = 32;
    localparam int reg_w  = 5;

    // primary opcodes
    localparam logic [5:0] op_special = 6'h00;
    localparam logic [5:0] op_addi    = 6'h08;
    localparam logic [5:0] op_addiu   = 6'h09;
    localparam logic [5:0] op_slti    = 6'h0a;
    localparam logic [5:0] op_sltiu   = 6'h0b;
    localparam logic [5:0] op_andi    = 6'h0c;
    localparam logic [5:0] op_ori     = 6'h0d;
    localparam logic [5:0] op_xori    = 6'h0e;
    localparam logic [5:0] op_lui     = 6'h0f;
    localparam logic [5:0] op_lb      = 6'h20;
    localparam logic [5:0] op_lh      = 6'h21;
    localparam logic [5:0] op_lw      = 6'h23;
    localparam logic [5:0] op_lbu     = 6'h24;
    localparam logic [5:0] op_lhu     = 6'h25;
    localparam logic [5:0] op_sb      = 6'h28;
    localparam logic [5:0] op_sh      = 6'h29;
    localparam logic [5:0] op_sw      = 6'h2b;

    // special function codes
    localparam logic [5:0] fn_sll  = 6'h00;
    localparam logic [5:0] fn_srl  = 6'h02;
    localparam logic [5:0] fn_sra  = 6'h03;
    localparam logic [5:0] fn_sllv = 6'h04;
    localparam logic [5:0] fn_srlv = 6'h06;
    localparam logic [5:0] fn_srav = 6'h07;
    localparam logic [5:0] fn_add  = 6'h20;
    localparam logic [5:0] fn_addu = 6'h21;
    localparam logic [5:0] fn_sub  = 6'h22;
    localparam logic [5:0] fn_subu = 6'h23;
    localparam logic [5:0] fn_and  = 6'h24;
    localparam logic [5:0] fn_or   = 6'h25;
    localparam logic [5:0] fn_xor  = 6'h26;
    localparam logic [5:0] fn_nor  = 6'h27;
    localparam logic [5:0] fn_slt  = 6'h2a;
    localparam logic [5:0] fn_sltu = 6'h2b;

    // cp0 cause codes
    localparam logic [4:0] exc_adel = 5'h04;
    localparam logic [4:0] exc_ades = 5'h05;
    localparam logic [4:0] exc_ri   = 5'h0a;
    localparam logic [4:0] exc_ov   = 5'h0c;

    typedef enum logic [3:0] {
        alu_add, alu_sub, alu_and, alu_or, alu_xor, alu_nor,
        alu_slt, alu_sltu, alu_sll, alu_srl, alu_sra
    } alu_op_e;

    typedef enum logic [3:0] {
        mem_none, mem_lb, mem_lbu, mem_lh, mem_lhu, mem_lw, mem_sb, mem_sh, mem_sw
    } mem_op_e;

    typedef union packed {
        struct packed {
            logic [5:0]       opcode;
            logic [reg_w-1:0] rs;
            logic [reg_w-1:0] rt;
            logic [reg_w-1:0] rd;
            logic [reg_w-1:0] shamt;
            logic [5:0]       funct;
        } r;
        struct packed {
            logic [5:0]       opcode;
            logic [reg_w-1:0] rs;
            logic [reg_w-1:0] rt;
            logic [15:0]      imm;
        } i;
    } inst_u;

    typedef struct packed {
        alu_op_e alu_op;
        logic    a_is_shamt;
        logic    b_is_imm;
        logic    is_lui;
        mem_op_e mem_op;
        logic    trap_on_ovf;
        logic    reserved;
        logic    writes_reg;
    } exec_ctrl_t;

    typedef struct packed {
        logic [data_w-1:0] pc;
        logic [data_w-1:0] result;
        mem_op_e           mem_op;
        logic [data_w-1:0] eaddr;
        logic [reg_w-1:0]  waddr;
        logic [data_w-1:0] rt_data;
    } exec_out_t;

endpackage

// ==== verilog/exec_stage_reg.sv ====
module exec_stage_reg (
    input  logic                        clk,
    input  logic                        resetn,
    input  logic                        valid_i,
    input  logic                        ready_i,
    input  logic [exec_pkg::data_w-1:0] pc_i,
    input  exec_pkg::exec_ctrl_t        ctrl_i,
    input  logic [exec_pkg::reg_w-1:0]  waddr_i,
    input  logic [exec_pkg::data_w-1:0] result_i,
    input  logic [exec_pkg::data_w-1:0] eaddr_i,
    input  logic [exec_pkg::data_w-1:0] rt_data_i,
    input  logic                        ovf_i,
    input  logic                        adel_i,
    input  logic                        ades_i,
    input  logic                        data_addr_ok_i,
    output logic                        block_o,
    output logic                        done_o,
    output logic                        commit_o,
    output logic [4:0]                  commit_code_o,
    output logic                        valid_o,
    output exec_pkg::exec_out_t         out_o
);
    import exec_pkg::*;

    logic done_q;
    logic exc;
    logic is_mem;

    assign exc    = ctrl_i.reserved || ovf_i || adel_i || ades_i;
    assign is_mem = (ctrl_i.mem_op != mem_none);

    assign block_o  = exc || done_q;
    assign done_o   = !is_mem || exc || done_q || data_addr_ok_i;
    assign commit_o = valid_i && exc;

    always_comb begin
        if (ctrl_i.reserved) begin
            commit_code_o = exc_ri;
        end else if (ovf_i) begin
            commit_code_o = exc_ov;
        end else if (adel_i) begin
            commit_code_o = exc_adel;
        end else if (ades_i) begin
            commit_code_o = exc_ades;
        end else begin
            commit_code_o = '0;
        end
    end

    // remembers a finished instruction while downstream stalls
    always_ff @(posedge clk) begin
        if (!resetn) begin
            done_q <= 1'b0;
        end else if (ready_i) begin
            done_q <= 1'b0;
        end else if (valid_i && done_o) begin
            done_q <= 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (!resetn) begin
            valid_o <= 1'b0;
        end else if (ready_i) begin
            valid_o <= valid_i && done_o && !exc;
        end
    end

    always_ff @(posedge clk) begin
        if (ready_i) begin
            out_o.pc      <= pc_i;
            out_o.result  <= result_i;
            out_o.mem_op  <= ctrl_i.mem_op;
            out_o.eaddr   <= eaddr_i;
            out_o.waddr   <= waddr_i;
            out_o.rt_data <= rt_data_i;
        end
    end

    // the done latch relies on a waiting instruction staying on the inputs
    assert property (@(posedge clk) disable iff (!resetn)
        valid_i && !(done_o && ready_i) |=> valid_i && $stable(pc_i) && $stable(ctrl_i))
        else $error("instruction withdrawn before it was accepted");

endmodule

// ==== verilog/exec_top.sv ====
module exec_top (
    input  logic                        clk,
    input  logic                        resetn,
    input  logic                        valid_i,
    input  logic [exec_pkg::data_w-1:0] pc_i,
    input  exec_pkg::inst_u             inst_i,
    input  logic [exec_pkg::data_w-1:0] rs_data_i,
    input  logic [exec_pkg::data_w-1:0] rt_data_i,
    output logic                        done_o,
    input  logic                        ready_i,
    output logic                        valid_o,
    output exec_pkg::exec_out_t         out_o,
    output logic                        data_req_o,
    output logic                        data_wr_o,
    output logic [3:0]                  data_wstrb_o,
    output logic [1:0]                  data_size_o,
    output logic [exec_pkg::data_w-1:0] data_addr_o,
    output logic [exec_pkg::data_w-1:0] data_wdata_o,
    input  logic                        data_addr_ok_i,
    output logic                        commit_o,
    output logic [4:0]                  commit_code_o
);
    import exec_pkg::*;

    exec_ctrl_t        ctrl;
    logic [reg_w-1:0]  waddr;
    logic [data_w-1:0] imm;
    logic [data_w-1:0] result;
    logic [data_w-1:0] eaddr;
    logic              ovf;
    logic              adel;
    logic              ades;
    logic              block;

    exec_decode u_decode (
        .inst_i  (inst_i),
        .ctrl_o  (ctrl),
        .waddr_o (waddr),
        .imm_o   (imm)
    );

    exec_alu u_alu (
        .ctrl_i    (ctrl),
        .inst_i    (inst_i),
        .rs_data_i (rs_data_i),
        .rt_data_i (rt_data_i),
        .imm_i     (imm),
        .result_o  (result),
        .ovf_o     (ovf)
    );

    exec_mem_req u_mem_req (
        .valid_i      (valid_i),
        .ctrl_i       (ctrl),
        .rs_data_i    (rs_data_i),
        .rt_data_i    (rt_data_i),
        .imm_i        (imm),
        .block_i      (block),
        .eaddr_o      (eaddr),
        .adel_o       (adel),
        .ades_o       (ades),
        .data_req_o   (data_req_o),
        .data_wr_o    (data_wr_o),
        .data_wstrb_o (data_wstrb_o),
        .data_size_o  (data_size_o),
        .data_addr_o  (data_addr_o),
        .data_wdata_o (data_wdata_o)
    );

    exec_stage_reg u_stage_reg (
        .clk            (clk),
        .resetn         (resetn),
        .valid_i        (valid_i),
        .ready_i        (ready_i),
        .pc_i           (pc_i),
        .ctrl_i         (ctrl),
        .waddr_i        (waddr),
        .result_i       (result),
        .eaddr_i        (eaddr),
        .rt_data_i      (rt_data_i),
        .ovf_i          (ovf),
        .adel_i         (adel),
        .ades_i         (ades),
        .data_addr_ok_i (data_addr_ok_i),
        .block_o        (block),
        .done_o         (done_o),
        .commit_o       (commit_o),
        .commit_code_o  (commit_code_o),
        .valid_o        (valid_o),
        .out_o          (out_o)
    );

endmodule
